//--- list.f
verilog/xbar_pkg.sv
verilog/axi_chan_if.sv
verilog/initiator_port.sv
verilog/target_arbiter.sv
verilog/xbar_top.sv
tb/xbar_properties.sv
tb/tb_xbar.sv

//--- Makefile
TOP := tb_xbar
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG) for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test completed successfully$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb/tb_xbar.sv
// Testbench for the read crossbar: drives both initiators, models four targets, checks each transfer
`timescale 1ns/10ps

module tb_xbar
  import xbar_pkg::*;
();

  localparam int N_ARB       = 2;
  localparam int N_RAND      = 40;
  localparam int MAX_BEATS   = 4;
  localparam int CYCLE_LIMIT =
    (NB_INIT * (N_ARB + N_RAND) + N_ARB) * (MAX_BEATS + 4) * 8 + 200;
  localparam int TQ_W        = ID_W_TARG + LEN_W + ADDR_W;

  logic                              clk;
  logic                              rst_n;
  logic [NB_INIT-1:0][ID_W-1:0]      s_ar_id_i;
  logic [NB_INIT-1:0][ADDR_W-1:0]    s_ar_addr_i;
  logic [NB_INIT-1:0][LEN_W-1:0]     s_ar_len_i;
  logic [NB_INIT-1:0]                s_ar_valid_i;
  logic [NB_INIT-1:0]                s_ar_ready_o;
  logic [NB_INIT-1:0][ID_W-1:0]      s_r_id_o;
  logic [NB_INIT-1:0][DATA_W-1:0]    s_r_data_o;
  logic [NB_INIT-1:0][RESP_W-1:0]    s_r_resp_o;
  logic [NB_INIT-1:0]                s_r_last_o;
  logic [NB_INIT-1:0]                s_r_valid_o;
  logic [NB_INIT-1:0]                s_r_ready_i;
  logic [NB_TARG-1:0][ID_W_TARG-1:0] m_ar_id_o;
  logic [NB_TARG-1:0][ADDR_W-1:0]    m_ar_addr_o;
  logic [NB_TARG-1:0][LEN_W-1:0]     m_ar_len_o;
  logic [NB_TARG-1:0]                m_ar_valid_o;
  logic [NB_TARG-1:0]                m_ar_ready_i;
  logic [NB_TARG-1:0][ID_W_TARG-1:0] m_r_id_i;
  logic [NB_TARG-1:0][DATA_W-1:0]    m_r_data_i;
  logic [NB_TARG-1:0][RESP_W-1:0]    m_r_resp_i;
  logic [NB_TARG-1:0]                m_r_last_i;
  logic [NB_TARG-1:0]                m_r_valid_i;
  logic [NB_TARG-1:0]                m_r_ready_o;

  integer            seed;
  int                mism_cnt;
  int                other_cnt;
  int                cycle_cnt;
  string             test_name;
  logic [NB_INIT-1:0] in_flight;
  logic [NB_INIT-1:0] routed;
  logic [ID_W-1:0]   cur_id [NB_INIT];
  logic [ADDR_W-1:0] cur_addr [NB_INIT];
  logic [LEN_W-1:0]  cur_len [NB_INIT];
  int                rx_beat [NB_INIT];
  logic [TQ_W-1:0]   tq [NB_TARG][$];
  int                tx_beat [NB_TARG];
  int                arb_log [$];
  int                arb_exp [$];

  xbar_top DUT (.*);

  always #4 clk = ~clk;

  // Expected target from the decode rule, region bits above the map dropped
  function automatic logic [TARG_SEL_W-1:0] ref_targ(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] region;
    region = (addr - MM_START) >> REGION_LSB;
    return region[TARG_SEL_W-1:0];
  endfunction

  function automatic logic [ID_W_TARG-1:0] ref_tid(input int init, input logic [ID_W-1:0] id);
    return {INIT_SEL_W'(init), id};
  endfunction

  function automatic logic [DATA_W-1:0] ref_data(input int targ, input logic [ADDR_W-1:0] addr,
                                                 input int beat);
    return (addr + DATA_W'(4 * beat)) ^ (DATA_W'(targ) << 24);
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    $display("Mismatch in %s, %s: expected %0h, actual %0h", test_name, what, exp_val, act_val);
    mism_cnt++;
  endtask

  task automatic print_summary();
    $display("Summary: %0d mismatches, %0d other errors", mism_cnt, other_cnt);
  endtask

  // Holds valid with a stable payload until the handshake
  task automatic issue_read(input int j, input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                            input logic [LEN_W-1:0] len);
    logic accepted;
    s_ar_id_i[j]    = id;
    s_ar_addr_i[j]  = addr;
    s_ar_len_i[j]   = len;
    s_ar_valid_i[j] = 1'b1;
    accepted = 1'b0;
    while (!accepted)
    begin
      @(negedge clk);
      accepted = s_ar_ready_o[j];
      @(posedge clk);
      #1;
    end
    s_ar_valid_i[j] = 1'b0;
  endtask

  // Even requests stay inside the map, odd ones alias from anywhere
  task automatic run_random(input int j);
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    for (int n = 0; n < N_RAND; n++)
    begin
      id   = ID_W'($random(seed));
      addr = $random(seed);
      len  = LEN_W'($random(seed) & 3);
      if (n % 2 == 0)
        addr = addr & 32'h0000_3fff;
      issue_read(j, id, addr, len);
    end
  endtask

  task automatic wait_idle();
    do
      @(posedge clk);
    while (in_flight != '0);
    #1;
  endtask

  task automatic drive_target(input int k);
    logic [TQ_W-1:0] head;
    m_ar_ready_i[k] = ($random(seed) & 3) != 0;
    if (tq[k].size() > 0)
    begin
      head = tq[k][0];
      m_r_valid_i[k] = 1'b1;
      m_r_id_i[k]    = head[TQ_W-1 -: ID_W_TARG];
      m_r_data_i[k]  = ref_data(k, head[ADDR_W-1:0], tx_beat[k]);
      m_r_last_i[k]  = tx_beat[k] == int'(head[ADDR_W +: LEN_W]);
    end
    else
    begin
      m_r_valid_i[k] = 1'b0;
      m_r_last_i[k]  = 1'b0;
    end
  endtask

  task automatic check_initiator(input int j);
    logic last_exp;
    if (in_flight[j] && s_ar_ready_o[j])
    begin
      $display("Error: initiator %0d ar_ready is high while its read is in flight", j);
      other_cnt++;
    end
    if (s_r_valid_o[j] && !in_flight[j])
    begin
      $display("Error: initiator %0d got a read beat with no read in flight", j);
      other_cnt++;
    end
    else if (s_r_valid_o[j] && s_r_ready_i[j])
    begin
      last_exp = rx_beat[j] == int'(cur_len[j]);
      if (s_r_id_o[j] !== cur_id[j])
        report_mismatch("r_id", cur_id[j], s_r_id_o[j]);
      if (s_r_data_o[j] !== ref_data(ref_targ(cur_addr[j]), cur_addr[j], rx_beat[j]))
        report_mismatch("r_data", ref_data(ref_targ(cur_addr[j]), cur_addr[j], rx_beat[j]),
                        s_r_data_o[j]);
      if (s_r_resp_o[j] !== '0)
        report_mismatch("r_resp", 0, s_r_resp_o[j]);
      if (s_r_last_o[j] !== last_exp)
        report_mismatch("r_last", last_exp, s_r_last_o[j]);
      rx_beat[j]++;
      if (last_exp)
        in_flight[j] = 1'b0;
    end
    if (s_ar_valid_i[j] && s_ar_ready_o[j])
    begin
      cur_id[j]    = s_ar_id_i[j];
      cur_addr[j]  = s_ar_addr_i[j];
      cur_len[j]   = s_ar_len_i[j];
      in_flight[j] = 1'b1;
      routed[j]    = 1'b0;
      rx_beat[j]   = 0;
    end
  endtask

  task automatic check_target(input int k);
    logic [ID_W_TARG-1:0] tid;
    int                   j;
    if (m_ar_valid_o[k] && m_ar_ready_i[k])
    begin
      tid = m_ar_id_o[k];
      j   = int'(tid[ID_W_TARG-1 -: INIT_SEL_W]);
      if (!in_flight[j] || routed[j])
      begin
        $display("Error: target %0d got a request initiator %0d did not issue", k, j);
        other_cnt++;
      end
      else
      begin
        if (k != int'(ref_targ(cur_addr[j])))
          report_mismatch("target index", ref_targ(cur_addr[j]), k);
        if (tid !== ref_tid(j, cur_id[j]))
          report_mismatch("ar_id", ref_tid(j, cur_id[j]), tid);
        if (m_ar_addr_o[k] !== cur_addr[j])
          report_mismatch("ar_addr", cur_addr[j], m_ar_addr_o[k]);
        if (m_ar_len_o[k] !== cur_len[j])
          report_mismatch("ar_len", cur_len[j], m_ar_len_o[k]);
        routed[j] = 1'b1;
      end
      tq[k].push_back({tid, m_ar_len_o[k], m_ar_addr_o[k]});
      if (test_name == "arbitration")
        arb_log.push_back(j);
    end
    if (m_r_valid_i[k] && m_r_ready_o[k])
    begin
      tx_beat[k]++;
      if (m_r_last_i[k])
      begin
        void'(tq[k].pop_front());
        tx_beat[k] = 0;
      end
    end
  endtask

  // Target models and initiator R back-pressure
  always @(posedge clk)
  begin
    #1;
    for (int k = 0; k < NB_TARG; k++)
      drive_target(k);
    for (int j = 0; j < NB_INIT; j++)
      s_r_ready_i[j] = ($random(seed) & 3) != 0;
  end

  // Sampled mid-cycle, where every handshake input is settled
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      for (int j = 0; j < NB_INIT; j++)
        check_initiator(j);
      for (int k = 0; k < NB_TARG; k++)
        check_target(k);
    end
  end

  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt == CYCLE_LIMIT)
    begin
      $display("Error: run hit the limit of %0d cycles, a read never completed", CYCLE_LIMIT);
      other_cnt++;
      print_summary();
      $display("Test failed");
      $finish;
    end
  end

  initial
  begin
    logic [ADDR_W-1:0] addr0;
    logic [ADDR_W-1:0] addr1;
    int                prev_win;
    int                first_win;
    seed         = 32'hda7a;
    clk          = 1'b0;
    rst_n        = 1'b0;
    s_ar_id_i    = '0;
    s_ar_addr_i  = '0;
    s_ar_len_i   = '0;
    s_ar_valid_i = '0;
    s_r_ready_i  = '0;
    m_ar_ready_i = '0;
    m_r_id_i     = '0;
    m_r_data_i   = '0;
    m_r_resp_i   = '0;
    m_r_last_i   = '0;
    m_r_valid_i  = '0;
    mism_cnt     = 0;
    other_cnt    = 0;
    cycle_cnt    = 0;
    in_flight    = '0;
    routed       = '0;
    tx_beat      = '{default: 0};
    rx_beat      = '{default: 0};
    test_name    = "reset";
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Both initiators hit target 2 in the same cycle, one through an alias
    test_name = "arbitration";
    // Reset leaves the last initiator as the previous winner
    prev_win  = NB_INIT - 1;
    for (int r = 0; r < N_ARB; r++)
    begin
      addr0 = ($random(seed) & 32'h0000_0ffc) | 32'h0000_2000;
      addr1 = ($random(seed) & ~32'h0000_3000) | 32'h0000_2000;
      first_win = (prev_win + 1) % NB_INIT;
      arb_exp.push_back(first_win);
      arb_exp.push_back((first_win + 1) % NB_INIT);
      fork
        issue_read(0, ID_W'(r + 3), addr0, LEN_W'(r + 1));
        issue_read(1, ID_W'(r + 9), addr1, LEN_W'(3));
      join
      wait_idle();
      // A lone read makes initiator 0 the last winner before the next contest
      issue_read(0, ID_W'(r), addr0, LEN_W'(0));
      arb_exp.push_back(0);
      prev_win = 0;
      wait_idle();
    end
    if (arb_log.size() != arb_exp.size())
    begin
      $display("Error: target 2 saw %0d grants during arbitration, expected %0d",
               arb_log.size(), arb_exp.size());
      other_cnt++;
    end
    else
    begin
      for (int i = 0; i < arb_log.size(); i++)
        if (arb_log[i] != arb_exp[i])
          report_mismatch("grant order", arb_exp[i], arb_log[i]);
    end

    test_name = "random";
    fork
      run_random(0);
      run_random(1);
    join
    wait_idle();

    print_summary();
    if (mism_cnt == 0 && other_cnt == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- tb/xbar_properties.sv
// Handshake and reset assertions on the AR output register, bound into every target arbiter
`timescale 1ns/10ps

module xbar_properties
  import xbar_pkg::*;
(
  input logic                 clk,
  input logic                 rst_n,
  input logic                 valid_i,
  // Equals the target ready whenever valid is high
  input logic                 ready_i,
  input logic [ID_W_TARG-1:0] id_i,
  input logic [ADDR_W-1:0]    addr_i,
  input logic [LEN_W-1:0]     len_i
);

  valid_held: assert property (@(posedge clk) disable iff (!rst_n)
    valid_i && !ready_i |=> valid_i)
    else $error("AR valid dropped before the target took the request");

  payload_stable: assert property (@(posedge clk) disable iff (!rst_n)
    valid_i && !ready_i |=> $stable({id_i, addr_i, len_i}))
    else $error("AR payload changed while valid was held");

  reset_clears: assert property (@(posedge clk) !rst_n |=> !valid_i)
    else $error("AR valid high in the cycle after reset");

endmodule

bind target_arbiter xbar_properties arb_props (
  .clk     ( clk       ),
  .rst_n   ( rst_n     ),
  .valid_i ( out_valid ),
  .ready_i ( load_en   ),
  .id_i    ( out_id    ),
  .addr_i  ( out_addr  ),
  .len_i   ( out_len   )
);

//--- verilog/xbar_top.sv
// Top level of the AXI read crossbar, two initiators to four targets over a fixed map
`timescale 1ns/10ps

module xbar_top
  import xbar_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst_n,

  // Initiator ports
  input  logic [NB_INIT-1:0][ID_W-1:0]        s_ar_id_i,
  input  logic [NB_INIT-1:0][ADDR_W-1:0]      s_ar_addr_i,
  input  logic [NB_INIT-1:0][LEN_W-1:0]       s_ar_len_i,
  input  logic [NB_INIT-1:0]                  s_ar_valid_i,
  output logic [NB_INIT-1:0]                  s_ar_ready_o,

  output logic [NB_INIT-1:0][ID_W-1:0]        s_r_id_o,
  output logic [NB_INIT-1:0][DATA_W-1:0]      s_r_data_o,
  output logic [NB_INIT-1:0][RESP_W-1:0]      s_r_resp_o,
  output logic [NB_INIT-1:0]                  s_r_last_o,
  output logic [NB_INIT-1:0]                  s_r_valid_o,
  input  logic [NB_INIT-1:0]                  s_r_ready_i,

  // Target ports
  output logic [NB_TARG-1:0][ID_W_TARG-1:0]   m_ar_id_o,
  output logic [NB_TARG-1:0][ADDR_W-1:0]      m_ar_addr_o,
  output logic [NB_TARG-1:0][LEN_W-1:0]       m_ar_len_o,
  output logic [NB_TARG-1:0]                  m_ar_valid_o,
  input  logic [NB_TARG-1:0]                  m_ar_ready_i,

  input  logic [NB_TARG-1:0][ID_W_TARG-1:0]   m_r_id_i,
  input  logic [NB_TARG-1:0][DATA_W-1:0]      m_r_data_i,
  input  logic [NB_TARG-1:0][RESP_W-1:0]      m_r_resp_i,
  input  logic [NB_TARG-1:0]                  m_r_last_i,
  input  logic [NB_TARG-1:0]                  m_r_valid_i,
  output logic [NB_TARG-1:0]                  m_r_ready_o
);

  // Request crossbar, indexed [initiator][target]
  logic [NB_INIT-1:0][NB_TARG-1:0]             req_valid;
  logic [NB_INIT-1:0][NB_TARG-1:0]             req_ready;
  logic [NB_INIT-1:0][NB_TARG-1:0][ID_W-1:0]   req_id;
  logic [NB_INIT-1:0][NB_TARG-1:0][ADDR_W-1:0] req_addr;
  logic [NB_INIT-1:0][NB_TARG-1:0][LEN_W-1:0]  req_len;

  // R ready claims, indexed [target][initiator]
  logic [NB_TARG-1:0][NB_INIT-1:0]             r_claim;

  for (genvar j = 0; j < NB_INIT; j++)
  begin : g_init
    ar_chan_if #(.ID_WIDTH(ID_W))      s_ar_if ();
    r_chan_if  #(.ID_WIDTH(ID_W))      s_r_if ();
    ar_chan_if #(.ID_WIDTH(ID_W))      req_if [NB_TARG-1:0] ();
    r_chan_if  #(.ID_WIDTH(ID_W_TARG)) rsp_if [NB_TARG-1:0] ();

    assign s_ar_if.id      = s_ar_id_i[j];
    assign s_ar_if.addr    = s_ar_addr_i[j];
    assign s_ar_if.len     = s_ar_len_i[j];
    assign s_ar_if.valid   = s_ar_valid_i[j];
    assign s_ar_ready_o[j] = s_ar_if.ready;

    assign s_r_id_o[j]    = s_r_if.id;
    assign s_r_data_o[j]  = s_r_if.data;
    assign s_r_resp_o[j]  = s_r_if.resp;
    assign s_r_last_o[j]  = s_r_if.last;
    assign s_r_valid_o[j] = s_r_if.valid;
    assign s_r_if.ready   = s_r_ready_i[j];

    for (genvar k = 0; k < NB_TARG; k++)
    begin : g_link
      assign req_valid[j][k] = req_if[k].valid;
      assign req_id[j][k]    = req_if[k].id;
      assign req_addr[j][k]  = req_if[k].addr;
      assign req_len[j][k]   = req_if[k].len;
      assign req_if[k].ready = req_ready[j][k];

      // Every target's R beat is offered to every initiator port
      assign rsp_if[k].id    = m_r_id_i[k];
      assign rsp_if[k].data  = m_r_data_i[k];
      assign rsp_if[k].resp  = m_r_resp_i[k];
      assign rsp_if[k].last  = m_r_last_i[k];
      assign rsp_if[k].valid = m_r_valid_i[k];
      assign r_claim[k][j]   = rsp_if[k].ready;
    end

    initiator_port #(
      .INIT_IDX ( j )
    ) initiator_port_i (
      .clk     ( clk     ),
      .rst_n   ( rst_n   ),
      .up_ar   ( s_ar_if ),
      .up_r    ( s_r_if  ),
      .down_ar ( req_if  ),
      .down_r  ( rsp_if  )
    );
  end

  for (genvar k = 0; k < NB_TARG; k++)
  begin : g_targ
    ar_chan_if #(.ID_WIDTH(ID_W))      arb_if [NB_INIT-1:0] ();
    ar_chan_if #(.ID_WIDTH(ID_W_TARG)) m_ar_if ();

    for (genvar j = 0; j < NB_INIT; j++)
    begin : g_link
      assign arb_if[j].valid = req_valid[j][k];
      assign arb_if[j].id    = req_id[j][k];
      assign arb_if[j].addr  = req_addr[j][k];
      assign arb_if[j].len   = req_len[j][k];
      assign req_ready[j][k] = arb_if[j].ready;
    end

    assign m_ar_id_o[k]    = m_ar_if.id;
    assign m_ar_addr_o[k]  = m_ar_if.addr;
    assign m_ar_len_o[k]   = m_ar_if.len;
    assign m_ar_valid_o[k] = m_ar_if.valid;
    assign m_ar_if.ready   = m_ar_ready_i[k];

    // At most one initiator port claims a given beat
    assign m_r_ready_o[k] = |r_claim[k];

    target_arbiter target_arbiter_i (
      .clk     ( clk     ),
      .rst_n   ( rst_n   ),
      .up_ar   ( arb_if  ),
      .down_ar ( m_ar_if )
    );
  end

endmodule

//--- verilog/target_arbiter.sv
// Target side of the read crossbar: round-robin grant, ID widening and the AR output register
`timescale 1ns/10ps

module target_arbiter
  import xbar_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,

  ar_chan_if.dst up_ar [NB_INIT-1:0],
  ar_chan_if.src down_ar
);

  logic [NB_INIT-1:0]             req_valid;
  logic [NB_INIT-1:0][ID_W-1:0]   req_id;
  logic [NB_INIT-1:0][ADDR_W-1:0] req_addr;
  logic [NB_INIT-1:0][LEN_W-1:0]  req_len;

  logic [INIT_SEL_W-1:0]          last_grant;
  logic [INIT_SEL_W-1:0]          win_idx;
  logic                           win_valid;
  logic                           load_en;

  logic                           out_valid;
  logic [ID_W_TARG-1:0]           out_id;
  logic [ADDR_W-1:0]              out_addr;
  logic [LEN_W-1:0]               out_len;

  for (genvar j = 0; j < NB_INIT; j++)
  begin : g_req
    assign req_valid[j] = up_ar[j].valid;
    assign req_id[j]    = up_ar[j].id;
    assign req_addr[j]  = up_ar[j].addr;
    assign req_len[j]   = up_ar[j].len;

    assign up_ar[j].ready = load_en && win_valid && (win_idx == INIT_SEL_W'(j));
  end

  // Register is free when empty or drained by the target this cycle
  assign load_en = !out_valid || down_ar.ready;

  // Search starts one past the last winner
  always_comb
  begin : rr_search
    logic [INIT_SEL_W-1:0] cand;
    win_valid = 1'b0;
    win_idx   = last_grant;
    for (int n = 1; n <= NB_INIT; n++)
    begin
      cand = INIT_SEL_W'((int'(last_grant) + n) % NB_INIT);
      if (!win_valid && req_valid[cand])
      begin
        win_valid = 1'b1;
        win_idx   = cand;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      out_valid  <= 1'b0;
      // Last initiator counts as the previous winner, so initiator 0 goes first
      last_grant <= INIT_SEL_W'(NB_INIT - 1);
    end
    else if (load_en)
    begin
      out_valid <= win_valid;
      if (win_valid)
      begin
        last_grant <= win_idx;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (load_en && win_valid)
    begin
      out_id   <= {win_idx, req_id[win_idx]};
      out_addr <= req_addr[win_idx];
      out_len  <= req_len[win_idx];
    end
  end

  assign down_ar.id    = out_id;
  assign down_ar.addr  = out_addr;
  assign down_ar.len   = out_len;
  assign down_ar.valid = out_valid;

endmodule

//--- verilog/initiator_port.sv
// Initiator side of the read crossbar: address decode, single outstanding read, R beat return
`timescale 1ns/10ps

module initiator_port
  import xbar_pkg::*;
#(
  parameter int INIT_IDX = 0
)(
  input  logic   clk,
  input  logic   rst_n,

  ar_chan_if.dst up_ar,
  r_chan_if.src  up_r,

  ar_chan_if.src down_ar [NB_TARG-1:0],
  r_chan_if.dst  down_r  [NB_TARG-1:0]
);

  logic [TARG_SEL_W-1:0]             dec_sel;
  logic [TARG_SEL_W-1:0]             cur_sel;
  logic                              busy;
  logic                              ar_hs;
  logic                              r_hit;
  logic                              r_take;
  logic [INIT_SEL_W-1:0]             r_prefix;

  logic [NB_TARG-1:0]                tgt_ar_ready;
  logic [NB_TARG-1:0]                r_valid_vec;
  logic [NB_TARG-1:0]                r_last_vec;
  logic [NB_TARG-1:0][ID_W_TARG-1:0] r_id_vec;
  logic [NB_TARG-1:0][DATA_W-1:0]    r_data_vec;
  logic [NB_TARG-1:0][RESP_W-1:0]    r_resp_vec;

  assign dec_sel = addr_to_targ(up_ar.addr);

  for (genvar k = 0; k < NB_TARG; k++)
  begin : g_tgt
    // Payload fans out, valid goes to the decoded target only
    assign down_ar[k].id    = up_ar.id;
    assign down_ar[k].addr  = up_ar.addr;
    assign down_ar[k].len   = up_ar.len;
    assign down_ar[k].valid = up_ar.valid && !busy && (dec_sel == TARG_SEL_W'(k));
    assign tgt_ar_ready[k]  = down_ar[k].ready;

    assign r_valid_vec[k] = down_r[k].valid;
    assign r_last_vec[k]  = down_r[k].last;
    assign r_id_vec[k]    = down_r[k].id;
    assign r_data_vec[k]  = down_r[k].data;
    assign r_resp_vec[k]  = down_r[k].resp;

    assign down_r[k].ready = r_take && (cur_sel == TARG_SEL_W'(k));
  end

  assign up_ar.ready = !busy && tgt_ar_ready[dec_sel];
  assign ar_hs       = up_ar.valid && up_ar.ready;

  // Only the target holding our read can carry our prefix
  assign r_prefix = r_id_vec[cur_sel][ID_W_TARG-1 -: INIT_SEL_W];
  assign r_hit    = busy && r_valid_vec[cur_sel] && (r_prefix == INIT_SEL_W'(INIT_IDX));
  assign r_take   = r_hit && up_r.ready;

  // Strip the prefix on the way back
  assign up_r.valid = r_hit;
  assign up_r.id    = r_id_vec[cur_sel][ID_W-1:0];
  assign up_r.data  = r_data_vec[cur_sel];
  assign up_r.resp  = r_resp_vec[cur_sel];
  assign up_r.last  = r_last_vec[cur_sel];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      cur_sel <= '0;
    end
    else if (ar_hs)
    begin
      busy    <= 1'b1;
      cur_sel <= dec_sel;
    end
    else if (r_take && r_last_vec[cur_sel])
    begin
      busy <= 1'b0;
    end
  end

endmodule

//--- verilog/axi_chan_if.sv
// AXI read-address and read-data channel bundles used between initiator ports and target arbiters
`timescale 1ns/10ps

interface ar_chan_if
  import xbar_pkg::*;
#(
  parameter int ID_WIDTH = ID_W
);

  logic [ID_WIDTH-1:0] id;
  logic [ADDR_W-1:0]   addr;
  logic [LEN_W-1:0]    len;
  logic                valid;
  logic                ready;

  modport src (output id, output addr, output len, output valid, input ready);
  modport dst (input id, input addr, input len, input valid, output ready);

endinterface

interface r_chan_if
  import xbar_pkg::*;
#(
  parameter int ID_WIDTH = ID_W
);

  logic [ID_WIDTH-1:0] id;
  logic [DATA_W-1:0]   data;
  logic [RESP_W-1:0]   resp;
  logic                last;
  logic                valid;
  logic                ready;

  modport src (
    output id, output data, output resp, output last, output valid,
    input  ready
  );
  modport dst (
    input  id, input data, input resp, input last, input valid,
    output ready
  );

endinterface

//--- verilog/xbar_pkg.sv
// Widths, port counts and the fixed memory map shared by the read crossbar and its testbench
package xbar_pkg;

  // Port counts
  localparam int NB_INIT = 2;
  localparam int NB_TARG = 4;

  // Channel field widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int LEN_W  = 8;
  localparam int RESP_W = 2;
  localparam int ID_W   = 4;

  localparam int INIT_SEL_W = $clog2(NB_INIT);
  localparam int TARG_SEL_W = $clog2(NB_TARG);

  // Initiator index rides in the top bits of the target-side ID
  localparam int ID_W_TARG = ID_W + INIT_SEL_W;

  // Four contiguous regions of equal size
  localparam logic [ADDR_W-1:0] MM_START   = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] MM_LEN     = 32'h0000_1000;
  localparam int                REGION_LSB = $clog2(MM_LEN);

  // Region bits above the map are dropped, so far addresses alias back in
  function automatic logic [TARG_SEL_W-1:0] addr_to_targ(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] offset;
    offset = addr - MM_START;
    return offset[REGION_LSB +: TARG_SEL_W];
  endfunction

endpackage
